//--- hdl/cuConfig_config.svh
`ifndef CU_CONFIG_CONFIG_SVH
`define CU_CONFIG_CONFIG_SVH

// ******************************
// datapath widths
// ******************************
`define INSTR_WIDTH      16    // instruction word
`define ADDR_WIDTH       16    // program address
`define REG_SEL_WIDTH    4     // register file select
`define IRQ_COUNT        4     // interrupt request lines

// ******************************
// start-up and vectoring
// ******************************
`define START_DELAY      40    // start cycles before first fetch
`define DELAY_CNT_WIDTH  6     // holds START_DELAY
`define IRQ_VECTOR_BASE  20    // vector of line 0
`define IRQ_VECTOR_STEP  10    // gap between line vectors

`endif

//--- hdl/cuPkg.sv
`include "cuConfig_config.svh"

package cuPkg;

    // ******************************
    // plain vector types
    // ******************************
    typedef logic [`INSTR_WIDTH-1:0]   instr_t;     // fetched instruction word
    typedef logic [`ADDR_WIDTH-1:0]    addr_t;      // program address
    typedef logic [`REG_SEL_WIDTH-1:0] regSel_t;    // register select
    typedef logic [3:0]                aluMode_t;   // alu operation
    typedef logic [`IRQ_COUNT-1:0]     irqVec_t;    // one bit per irq line

    // ******************************
    // decode and sequencing enums
    // ******************************
    typedef enum logic [3:0] {
        clsRegImm, clsIo, clsRegReg, clsRegPtr, clsBranch,
        clsJmp, clsCall, clsRet, clsNopHlt, clsOther
    } instrClass_t;

    typedef enum logic [2:0] {
        seqStart, seqReset, seqPart1, seqPart2,
        seqPart3, seqJmp, seqCall, seqInterrupt
    } seqState_t;

    // ******************************
    // control word groups
    // ******************************
    typedef struct packed {
        logic       src;            // 0 alu out, 1 data/io out
        regSel_t    outBSelect;     // port B read select
        logic       writeEnable;
        logic       add;            // pointer add on port B pair
        logic [1:0] constSrc;       // 00 +1, 01 -1
    } regFileCtrl_t;

    typedef struct packed {
        logic       srcASelect;     // 0 register file
        logic [1:0] srcBSelect;     // 00 reg B, 10 immediate
        aluMode_t   mode;
    } aluCtrl_t;

    typedef struct packed {
        logic [2:0] dataSelect;     // write data source
        logic [1:0] ioAddressSelect;// 00 ptr, 01 io port, 10 ptr+1
        logic       ioWriteEn;
        logic       ioReadEn;
    } memCtrl_t;

    typedef struct packed {
        logic [1:0] srcSelect;      // 00 alu flags, 11 clear ie
        logic       flagEnable;
    } statusCtrl_t;

    typedef struct packed {
        logic [2:0] addrSelect;     // next fetch address source
        logic       readEnable;
        logic       pcWriteEn;
    } fetchCtrl_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } flags_t;

endpackage

//--- hdl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  cuPkg::instr_t      instr,
    input  cuPkg::flags_t      flags,
    output cuPkg::instrClass_t instrClass,
    output logic               condMet,
    output logic               uninterruptible
);

    logic [3:0] lowNib;     // opcode nibble
    logic [3:0] midNib;     // sub-opcode nibble
    logic       isHlt;
    logic       isRet;

    assign lowNib = instr[3:0];
    assign midNib = instr[7:4];
    assign isHlt  = (instr == '1);
    assign isRet  = (instr[12:0] == 13'h0E4F);

    // ******************************
    // classification, first match wins
    // ******************************
    always_comb begin
        if (lowNib inside {[4'd1:4'd7]}) begin
            instrClass = cuPkg::clsRegImm;              // mode in [2:0]
        end else if (lowNib == 4'd8 || lowNib == 4'd9) begin
            instrClass = cuPkg::clsIo;                  // bit 0 set is out
        end else if (lowNib == 4'd10 && midNib inside {[4'd1:4'd9]}) begin
            instrClass = cuPkg::clsRegReg;
        end else if (lowNib == 4'd10 && midNib inside {[4'd12:4'd15]} && !instr[8]) begin
            instrClass = cuPkg::clsRegPtr;              // bit 5 set is load
        end else if (lowNib == 4'd14) begin
            instrClass = cuPkg::clsBranch;
        end else if (instr[12:0] == 13'h0E2F) begin
            instrClass = cuPkg::clsJmp;
        end else if (instr[12:0] == 13'h0E3F) begin
            instrClass = cuPkg::clsCall;
        end else if (isRet) begin
            instrClass = cuPkg::clsRet;
        end else if (instr == '0 || isHlt) begin
            instrClass = cuPkg::clsNopHlt;              // split on bit 0
        end else begin
            instrClass = cuPkg::clsOther;               // just fetch next
        end
    end

    // ******************************
    // branch condition
    // ******************************
    always_comb begin
        case (instr[15:13])
            3'd1:    condMet = flags.carry;
            3'd2:    condMet = !flags.carry;
            3'd3:    condMet = flags.zero;
            3'd4:    condMet = !flags.zero;
            3'd5:    condMet = flags.negative;
            3'd6:    condMet = !flags.negative;
            default: condMet = 1'b1;                    // codes 0 and 7 always
        endcase
    end

    // halt and return must finish before an irq is taken
    assign uninterruptible = isHlt || isRet;

endmodule

//--- hdl/interruptArbiter.sv
`timescale 1ns/1ps
`include "cuConfig_config.svh"

module interruptArbiter (
    input  cuPkg::irqVec_t irq,
    input  logic           irqAck,
    output logic           irqPending,
    output cuPkg::addr_t   interruptVector,
    output cuPkg::irqVec_t irqClr
);

    cuPkg::irqVec_t grant;      // one-hot winner

    // fixed priority, line 0 wins, scan from top so lowest index lands last
    always_comb begin
        grant           = '0;
        interruptVector = '0;                           // no line pending
        for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
            if (irq[i]) begin
                grant           = '0;
                grant[i]        = 1'b1;
                interruptVector = cuPkg::addr_t'(`IRQ_VECTOR_BASE + i * `IRQ_VECTOR_STEP);
            end
        end
    end

    assign irqPending = |irq;
    assign irqClr     = irqAck ? grant : '0;          // clear only on entry

endmodule

//--- hdl/resetSequencer.sv
`timescale 1ns/1ps
`include "cuConfig_config.svh"

module resetSequencer (
    input  logic clk,
    input  logic arstN,
    input  logic cpuReset,
    input  logic inStart,
    output logic resetSync,
    output logic startDone
);

    localparam logic [`DELAY_CNT_WIDTH-1:0] startDelay = `START_DELAY;

    logic                        syncStage;   // first sync flop
    logic [`DELAY_CNT_WIDTH-1:0] delayCnt;    // cycles spent in start

    // ******************************
    // soft reset synchronizer
    // ******************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncStage <= 1'b1;                  // come up held in reset
            resetSync <= 1'b1;
        end else begin
            syncStage <= cpuReset;
            resetSync <= syncStage;
        end
    end

    // start delay, runs only while the sequencer sits in start
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            delayCnt <= '0;
        end else if (inStart) begin
            delayCnt <= delayCnt + 1'b1;
        end else begin
            delayCnt <= '0;
        end
    end

    assign startDone = (delayCnt == startDelay);

endmodule

//--- hdl/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer (
    input  logic                clk,
    input  logic                arstN,
    input  cuPkg::instr_t       instr,
    input  cuPkg::instrClass_t  instrClass,
    input  logic                condMet,
    input  logic                uninterruptible,
    input  logic                irqPending,
    input  logic                interruptEnable,
    input  logic                resetSync,
    input  logic                startDone,
    output cuPkg::regFileCtrl_t regFileCtrl,
    output cuPkg::aluCtrl_t     aluCtrl,
    output cuPkg::memCtrl_t     memCtrl,
    output cuPkg::statusCtrl_t  statusCtrl,
    output cuPkg::fetchCtrl_t   fetchCtrl,
    output logic                irqAck,
    output logic                inStart,
    output logic                resetOut
);

    localparam cuPkg::regSel_t spLowSel = 4'b1110;     // stack pointer low byte

    cuPkg::seqState_t state;
    cuPkg::seqState_t nextState;
    logic             inPart1;
    logic             inPart2;
    logic             inPart3;
    logic             retDone;     // last cycle of ret, or untaken

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cuPkg::seqStart;
        end else begin
            state <= nextState;
        end
    end

    assign inPart1  = (state == cuPkg::seqPart1);
    assign inPart2  = (state == cuPkg::seqPart2);
    assign inPart3  = (state == cuPkg::seqPart3);
    assign retDone  = (inPart1 && !condMet) || inPart3;
    assign irqAck   = (state == cuPkg::seqInterrupt);
    assign inStart  = (state == cuPkg::seqStart);
    assign resetOut = (state == cuPkg::seqStart) || (state == cuPkg::seqReset);

    // ******************************
    // control word and next state
    // ******************************
    always_comb begin
        regFileCtrl            = '0;
        regFileCtrl.outBSelect = {instr[11:9], 1'b0};   // pointer pair, mostly unused
        aluCtrl                = '0;                    // reg A, reg B, pass A
        memCtrl                = '0;
        statusCtrl             = '0;
        fetchCtrl              = '0;                    // pc, nothing written
        nextState              = cuPkg::seqPart1;

        case (state)
            cuPkg::seqStart: begin
                statusCtrl           = '{srcSelect: 2'b11, flagEnable: 1'b1}; // ie off
                fetchCtrl.readEnable = 1'b1;
                fetchCtrl.pcWriteEn  = startDone;       // first fetch lands here
                nextState            = startDone ? cuPkg::seqPart1 : cuPkg::seqStart;
            end

            cuPkg::seqReset: begin
                statusCtrl           = '{srcSelect: 2'b11, flagEnable: 1'b1};
                fetchCtrl.readEnable = 1'b1;
                fetchCtrl.pcWriteEn  = 1'b1;
                nextState            = resetSync ? cuPkg::seqReset : cuPkg::seqPart1;
            end

            cuPkg::seqInterrupt: begin
                regFileCtrl.outBSelect = spLowSel;
                regFileCtrl.add        = 1'b1;          // sp--
                regFileCtrl.constSrc   = 2'b01;
                memCtrl.dataSelect     = 3'b011;        // return address high byte
                memCtrl.ioWriteEn      = 1'b1;
                statusCtrl             = '{srcSelect: 2'b11, flagEnable: 1'b1};
                fetchCtrl              = '{addrSelect: 3'b010, readEnable: 1'b1,
                                           pcWriteEn: 1'b1};   // jump to vector
            end

            cuPkg::seqJmp: begin
                fetchCtrl = '{addrSelect: 3'b011, readEnable: 1'b1, pcWriteEn: 1'b1};
            end

            cuPkg::seqCall: begin
                regFileCtrl.outBSelect = spLowSel;
                regFileCtrl.add        = 1'b1;
                regFileCtrl.constSrc   = 2'b01;         // sp--
                memCtrl.dataSelect     = 3'b001;        // pc+1 high byte
                memCtrl.ioWriteEn      = 1'b1;
                fetchCtrl              = '{addrSelect: 3'b011, readEnable: 1'b1,
                                           pcWriteEn: 1'b1};   // target word
            end

            default: begin                              // part 1 to 3
                if (resetSync) begin
                    nextState = cuPkg::seqReset;        // park, no fetch
                end else if (inPart1 && interruptEnable && irqPending && !uninterruptible) begin
                    regFileCtrl.outBSelect = spLowSel;
                    regFileCtrl.add        = 1'b1;
                    regFileCtrl.constSrc   = 2'b01;     // sp--
                    memCtrl.dataSelect     = 3'b100;    // current address low byte
                    memCtrl.ioWriteEn      = 1'b1;
                    statusCtrl             = '{srcSelect: 2'b11, flagEnable: 1'b1};
                    fetchCtrl.addrSelect   = 3'b010;
                    nextState              = cuPkg::seqInterrupt;
                end else begin
                    fetchCtrl.readEnable = 1'b1;
                    fetchCtrl.pcWriteEn  = 1'b1;
                    case (instrClass)
                        cuPkg::clsRegImm: begin
                            regFileCtrl.writeEnable = 1'b1;
                            aluCtrl.srcBSelect      = 2'b10;              // 8-bit immediate
                            aluCtrl.mode            = {1'b0, instr[2:0]};
                            statusCtrl.flagEnable   = (instr[2:0] != 3'b001); // ldi keeps flags
                        end
                        cuPkg::clsIo: begin
                            regFileCtrl.src         = 1'b1;               // io read data
                            regFileCtrl.writeEnable = inPart2;
                            memCtrl.ioAddressSelect = 2'b01;              // port from instr
                            memCtrl.ioWriteEn       = instr[0];
                            memCtrl.ioReadEn        = !instr[0] && inPart1;
                            fetchCtrl.readEnable    = instr[0] || inPart2;
                            fetchCtrl.pcWriteEn     = instr[0] || inPart2;
                            if (!instr[0] && inPart1) begin
                                nextState = cuPkg::seqPart2;              // in needs data back
                            end
                        end
                        cuPkg::clsRegReg: begin
                            regFileCtrl.outBSelect  = instr[11:8];
                            regFileCtrl.writeEnable = 1'b1;
                            aluCtrl.mode            = instr[7:4];
                            statusCtrl.flagEnable   = (instr[7:4] != 4'b0001); // mov keeps flags
                        end
                        cuPkg::clsRegPtr: begin
                            regFileCtrl.src         = 1'b1;
                            regFileCtrl.writeEnable = instr[5];           // load
                            regFileCtrl.add         = inPart1;            // post inc or dec
                            regFileCtrl.constSrc    = instr[4] ? 2'b01 : 2'b00;
                            memCtrl.ioWriteEn       = !instr[5];          // store
                            memCtrl.ioReadEn        = instr[5] && inPart1;
                            fetchCtrl.readEnable    = !instr[5] || inPart2;
                            fetchCtrl.pcWriteEn     = !instr[5] || inPart2;
                            if (instr[5] && inPart1) begin
                                nextState = cuPkg::seqPart2;
                            end
                        end
                        cuPkg::clsBranch: begin
                            if (condMet) begin
                                fetchCtrl.addrSelect = instr[0] ? 3'b100 : 3'b110;
                            end
                        end
                        cuPkg::clsJmp: begin
                            fetchCtrl.addrSelect = condMet ? 3'b000 : 3'b001; // skip target word
                            nextState = condMet ? cuPkg::seqJmp : cuPkg::seqPart1;
                        end
                        cuPkg::clsCall: begin
                            regFileCtrl.add      = condMet;
                            regFileCtrl.constSrc = 2'b01;
                            memCtrl.dataSelect   = 3'b010;                // pc+1 low byte
                            memCtrl.ioWriteEn    = condMet;
                            fetchCtrl.addrSelect = condMet ? 3'b000 : 3'b001;
                            fetchCtrl.pcWriteEn  = !condMet;              // high byte still due
                            nextState = condMet ? cuPkg::seqCall : cuPkg::seqPart1;
                        end
                        cuPkg::clsRet: begin
                            regFileCtrl.add         = (inPart1 && condMet) || inPart2; // sp++
                            memCtrl.ioAddressSelect = 2'b10;              // sp+1
                            memCtrl.ioReadEn        = (inPart1 && condMet) || inPart2;
                            fetchCtrl.addrSelect    = inPart1 ? 3'b000 : 3'b101;
                            fetchCtrl.readEnable    = retDone;
                            fetchCtrl.pcWriteEn     = retDone;
                            if (!retDone) begin
                                nextState = inPart1 ? cuPkg::seqPart2 : cuPkg::seqPart3;
                            end
                        end
                        cuPkg::clsNopHlt: begin
                            fetchCtrl.readEnable = !instr[0];             // hlt spins
                            fetchCtrl.pcWriteEn  = !instr[0];
                        end
                        default: begin
                            fetchCtrl.addrSelect = 3'b000;                // unknown, step on
                        end
                    endcase
                end
            end
        endcase
    end

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                clk,
    input  logic                arstN,
    input  logic                cpuReset,
    input  cuPkg::instr_t       instr,
    input  cuPkg::flags_t       flags,
    input  logic                interruptEnable,
    input  cuPkg::irqVec_t      irq,
    output cuPkg::regFileCtrl_t regFileCtrl,
    output cuPkg::aluCtrl_t     aluCtrl,
    output cuPkg::memCtrl_t     memCtrl,
    output cuPkg::statusCtrl_t  statusCtrl,
    output cuPkg::fetchCtrl_t   fetchCtrl,
    output cuPkg::addr_t        interruptVector,
    output cuPkg::irqVec_t      irqClr,
    output logic                resetOut
);

    logic               resetSync;
    logic               startDone;
    logic               inStart;
    cuPkg::instrClass_t instrClass;
    logic               condMet;
    logic               uninterruptible;
    logic               irqPending;
    logic               irqAck;

    // ******************************
    // reset and start delay
    // ******************************
    resetSequencer resetSeq_i (
        .clk       (clk),
        .arstN     (arstN),
        .cpuReset  (cpuReset),
        .inStart   (inStart),
        .resetSync (resetSync),
        .startDone (startDone)
    );

    instrDecoder decoder_i (
        .instr           (instr),
        .flags           (flags),
        .instrClass      (instrClass),
        .condMet         (condMet),
        .uninterruptible (uninterruptible)
    );

    interruptArbiter arbiter_i (
        .irq             (irq),
        .irqAck          (irqAck),
        .irqPending      (irqPending),
        .interruptVector (interruptVector),
        .irqClr          (irqClr)
    );

    // ******************************
    // sequencing fsm
    // ******************************
    controlSequencer sequencer_i (
        .clk             (clk),
        .arstN           (arstN),
        .instr           (instr),
        .instrClass      (instrClass),
        .condMet         (condMet),
        .uninterruptible (uninterruptible),
        .irqPending      (irqPending),
        .interruptEnable (interruptEnable),
        .resetSync       (resetSync),
        .startDone       (startDone),
        .regFileCtrl     (regFileCtrl),
        .aluCtrl         (aluCtrl),
        .memCtrl         (memCtrl),
        .statusCtrl      (statusCtrl),
        .fetchCtrl       (fetchCtrl),
        .irqAck          (irqAck),
        .inStart         (inStart),
        .resetOut        (resetOut)
    );

endmodule

//--- verif/controlUnitTb.sv
`timescale 1ns/1ps
`include "cuConfig_config.svh"

module controlUnitTb;

    logic                clk;
    logic                arstN;
    logic                cpuReset;
    cuPkg::instr_t       instr;
    cuPkg::flags_t       flags;
    logic                interruptEnable;
    cuPkg::irqVec_t      irq;
    cuPkg::regFileCtrl_t regFileCtrl;
    cuPkg::aluCtrl_t     aluCtrl;
    cuPkg::memCtrl_t     memCtrl;
    cuPkg::statusCtrl_t  statusCtrl;
    cuPkg::fetchCtrl_t   fetchCtrl;
    cuPkg::addr_t        interruptVector;
    cuPkg::irqVec_t      irqClr;
    logic                resetOut;

    integer      seed;          // $random state
    logic [31:0] rnd;
    int          errCount;
    int          checkCount;
    int          testCount;
    int          errAtStart;    // errors before the running test

    controlUnit dut_i (.*);

    always #50 clk = ~clk;      // 100 ns period

    // ******************************
    // check and drive helpers
    // ******************************
    task automatic checkBit(input string what, input logic got, input logic exp);
        checkCount++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic checkWord(input string what, input logic [15:0] got, input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errCount++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout at %0t: %s never happened", $time, what);
        errCount++;
    endtask

    // drive on the falling edge and let the comb outputs settle
    task automatic applyCycle(input cuPkg::instr_t w, input cuPkg::flags_t f,
                              input logic ie, input cuPkg::irqVec_t rq);
        @(negedge clk);
        instr           = w;
        flags           = f;
        interruptEnable = ie;
        irq             = rq;
        #10;
    endtask

    task automatic reportTest(input string name);
        testCount++;
        if (errCount == errAtStart) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    // condition table indexed by code with codes 0 and 7 always true
    function automatic logic branchTaken(input logic [2:0] code, input cuPkg::flags_t f);
        logic [7:0] table8;
        table8 = {1'b1, !f.negative, f.negative, !f.zero, f.zero, !f.carry, f.carry, 1'b1};
        return table8[code];
    endfunction

    function automatic int lowestPending(input cuPkg::irqVec_t rq);
        for (int i = 0; i < `IRQ_COUNT; i++) begin
            if (rq[i]) return i;
        end
        return -1;
    endfunction

    // ******************************
    // directed tests
    // ******************************
    task automatic startSequence();
        int n;
        checkBit("resetOut under arstN", resetOut, 1'b1);
        checkBit("pcWriteEn under arstN", fetchCtrl.pcWriteEn, 1'b0);
        @(negedge clk);
        arstN = 1'b1;
        #10;
        n = 1;                                          // cycle up to first rising edge
        while (!fetchCtrl.pcWriteEn && n < 100) begin
            checkBit("resetOut in start", resetOut, 1'b1);
            checkBit("reg write in start", regFileCtrl.writeEnable, 1'b0);
            checkBit("ioWriteEn in start", memCtrl.ioWriteEn, 1'b0);
            checkBit("ioReadEn in start", memCtrl.ioReadEn, 1'b0);
            checkBit("flagEnable in start", statusCtrl.flagEnable, 1'b1);
            checkWord("status src in start", 16'(statusCtrl.srcSelect), 16'd3);
            applyCycle('0, '0, 1'b0, '0);
            n++;
        end
        if (!fetchCtrl.pcWriteEn) begin
            reportTimeout("first pcWriteEn pulse after release");
        end else begin
            checkWord("first pcWriteEn cycle", 16'(n), 16'(`START_DELAY + 1));
            applyCycle('0, '0, 1'b0, '0);
            checkBit("resetOut after start", resetOut, 1'b0);
        end
        reportTest("start sequence");
    endtask

    task automatic aluInstructions();
        logic [3:0]    nib;
        cuPkg::instr_t w;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            nib = {1'b0, rnd[2:0]};
            if (nib == 4'd0) nib = 4'd7;                // keep in R_I range
            if (i == 0) nib = 4'd1;                     // ldi at least once
            w = {rnd[31:20], nib};
            applyCycle(w, '0, 1'b0, '0);
            checkBit("R_I reg write", regFileCtrl.writeEnable, 1'b1);
            checkWord("R_I alu mode", 16'(aluCtrl.mode), 16'(nib[2:0]));
            checkBit("R_I flagEnable", statusCtrl.flagEnable, nib[2:0] != 3'b001);
            checkBit("R_I pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
            rnd = $random(seed);
            nib = rnd[11:8];                            // R_R mode in bits 7..4
            if (nib == 4'd0 || nib > 4'd9 || i == 0) nib = 4'd1;
            w = {rnd[27:20], nib, 4'hA};
            applyCycle(w, '0, 1'b0, '0);
            checkBit("R_R reg write", regFileCtrl.writeEnable, 1'b1);
            checkWord("R_R alu mode", 16'(aluCtrl.mode), 16'(nib));
            checkBit("R_R flagEnable", statusCtrl.flagEnable, nib != 4'd1);
            checkBit("R_R pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
        end
        reportTest("alu instructions");
    endtask

    task automatic branchConditions();
        cuPkg::flags_t f;
        cuPkg::instr_t w;
        logic [2:0]    expSel;
        for (int code = 0; code < 8; code++) begin
            repeat (4) begin
                rnd    = $random(seed);
                f      = cuPkg::flags_t'(rnd[2:0]);
                w      = {3'(code), rnd[12:4], 4'hE};
                expSel = branchTaken(w[15:13], f) ? (w[0] ? 3'b100 : 3'b110) : 3'b000;
                applyCycle(w, f, 1'b0, '0);
                checkWord("BR addrSelect", 16'(fetchCtrl.addrSelect), 16'(expSel));
                checkBit("BR pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
            end
        end
        reportTest("branch conditions");
    endtask

    task automatic multiCycleInstructions();
        cuPkg::instr_t w;
        rnd = $random(seed);
        w   = {rnd[15:4], 4'h8};                        // IO with bit 0 clear is IN
        applyCycle(w, '0, 1'b0, '0);
        checkBit("IN ioReadEn", memCtrl.ioReadEn, 1'b1);
        checkBit("IN first pcWriteEn", fetchCtrl.pcWriteEn, 1'b0);
        applyCycle(w, '0, 1'b0, '0);                    // word held while pc stalls
        checkBit("IN reg write", regFileCtrl.writeEnable, 1'b1);
        checkBit("IN second pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
        applyCycle(16'h0E3F, '0, 1'b0, '0);             // code 0 is always taken
        checkBit("CALL stack write", memCtrl.ioWriteEn, 1'b1);
        checkWord("CALL low dataSelect", 16'(memCtrl.dataSelect), 16'd2);
        checkBit("CALL first pcWriteEn", fetchCtrl.pcWriteEn, 1'b0);
        applyCycle(16'h0E3F, '0, 1'b0, '0);
        checkWord("CALL high dataSelect", 16'(memCtrl.dataSelect), 16'd1);
        checkWord("CALL addrSelect", 16'(fetchCtrl.addrSelect), 16'd3);
        checkBit("CALL second pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
        applyCycle(16'h2E3F, '0, 1'b0, '0);             // carry clear so untaken
        checkWord("untaken CALL addrSelect", 16'(fetchCtrl.addrSelect), 16'd1);
        checkBit("untaken CALL pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
        checkBit("untaken CALL stack write", memCtrl.ioWriteEn, 1'b0);
        applyCycle('0, '0, 1'b0, '0);
        checkWord("fetch after CALL", 16'(fetchCtrl.addrSelect), 16'd0);
        reportTest("multi-cycle instructions");
    endtask

    task automatic interruptEntry();
        cuPkg::irqVec_t rq;
        int             line;
        rq   = 4'b0110;
        line = lowestPending(rq);
        applyCycle('0, '0, 1'b1, rq);
        checkWord("interrupt vector", interruptVector, 16'd30);    // line 1 vector
        checkBit("entry stack write", memCtrl.ioWriteEn, 1'b1);
        checkWord("entry dataSelect", 16'(memCtrl.dataSelect), 16'd4);
        checkBit("entry sp decrement", regFileCtrl.add, 1'b1);
        checkWord("entry status src", 16'(statusCtrl.srcSelect), 16'd3);
        checkBit("entry first pcWriteEn", fetchCtrl.pcWriteEn, 1'b0);
        checkWord("irqClr early", 16'(irqClr), 16'd0);
        applyCycle('0, '0, 1'b1, rq);                   // lines held until cleared
        checkWord("irqClr one-hot", 16'(irqClr), 16'(cuPkg::irqVec_t'(1 << line)));
        checkWord("entry high dataSelect", 16'(memCtrl.dataSelect), 16'd3);
        checkWord("entry addrSelect", 16'(fetchCtrl.addrSelect), 16'd2);
        checkBit("entry second pcWriteEn", fetchCtrl.pcWriteEn, 1'b1);
        applyCycle('0, '0, 1'b0, '0);
        checkWord("irqClr after entry", 16'(irqClr), 16'd0);
        repeat (6) begin
            applyCycle(16'hFFFF, '0, 1'b1, 4'b0001);    // hlt blocks entry
            checkBit("HLT pcWriteEn", fetchCtrl.pcWriteEn, 1'b0);
            checkBit("HLT stack write", memCtrl.ioWriteEn, 1'b0);
            checkWord("HLT irqClr", 16'(irqClr), 16'd0);
        end
        applyCycle('0, '0, 1'b0, '0);
        checkBit("fetch after HLT", fetchCtrl.pcWriteEn, 1'b1);
        reportTest("interrupt entry");
    endtask

    task automatic softReset();
        int   n;
        logic lastPc;                                   // pcWriteEn on last reset cycle
        @(negedge clk);
        cpuReset = 1'b1;
        #10;
        n = 0;
        while (!resetOut && n < 20) begin
            applyCycle('0, '0, 1'b0, '0);
            n++;
        end
        if (!resetOut) begin
            reportTimeout("resetOut rising after cpuReset");
        end else begin
            checkBit("reg write in reset", regFileCtrl.writeEnable, 1'b0);
            checkBit("ioWriteEn in reset", memCtrl.ioWriteEn, 1'b0);
            checkWord("status src in reset", 16'(statusCtrl.srcSelect), 16'd3);
            @(negedge clk);
            cpuReset = 1'b0;
            #10;
            lastPc = fetchCtrl.pcWriteEn;
            n      = 0;
            while (resetOut && n < 20) begin
                lastPc = fetchCtrl.pcWriteEn;
                checkBit("ioReadEn in reset", memCtrl.ioReadEn, 1'b0);
                applyCycle('0, '0, 1'b0, '0);
                n++;
            end
            if (resetOut) begin
                reportTimeout("resetOut falling after cpuReset release");
            end else begin
                checkBit("pcWriteEn leaving reset", lastPc, 1'b1);
                checkBit("fetch after reset", fetchCtrl.pcWriteEn, 1'b1);
            end
        end
        reportTest("soft reset");
    endtask

    // ******************************
    // main sequence
    // ******************************
    initial begin
        seed            = 32'h12a6ed4a;
        clk             = 1'b0;
        arstN           = 1'b0;
        cpuReset        = 1'b0;
        instr           = '0;                           // nop
        flags           = '0;
        interruptEnable = 1'b0;
        irq             = '0;
        errCount        = 0;
        checkCount      = 0;
        testCount       = 0;
        errAtStart      = 0;
        repeat (16) @(posedge clk);
        startSequence();
        aluInstructions();
        branchConditions();
        multiCycleInstructions();
        interruptEntry();
        softReset();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hdl
hdl/cuPkg.sv
hdl/instrDecoder.sv
hdl/interruptArbiter.sv
hdl/resetSequencer.sv
hdl/controlSequencer.sv
hdl/controlUnit.sv
verif/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the control unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module controlUnitTb -o controlUnitSim

./obj_dir/controlUnitSim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation finished cleanly"
